// ==== oled_pkg.sv ====
package oled_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Link and geometry types.
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [7:0] oled_byte_t;      // One byte on the SPI link.
    typedef logic [2:0] oled_page_t;      // Page 0..7.
    typedef logic [6:0] oled_col_t;       // Column 0..127.
    typedef logic [9:0] oled_pix_addr_t;  // {page, column} into frame memory.
    typedef logic       oled_dc_t;        // D/C pin level.

    // D/C pin. Low selects the command register.
    localparam oled_dc_t DC_CMD  = 1'b0;
    localparam oled_dc_t DC_DATA = 1'b1;

    // Panel geometry, 128x64 in pages of 8 rows.
    localparam int NUM_PAGES = 8;
    localparam int NUM_COLS  = 128;

    // Commands actually sent. ROM entry INIT_LEN is the end marker.
    localparam int INIT_LEN = 28;

    ////////////////////////////////////////////////////////////////////////////
    // State machines.
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        INIT_FETCH,     // Index on ROM address.
        INIT_WAIT_ROM,  // ROM data lands.
        INIT_REQUEST,   // Byte held at arbiter.
        INIT_FINISHED   // Parked until reset.
    } init_state_t;

    typedef enum logic [2:0] {
        PW_IDLE,
        PW_CMD_PAGE,    // B0 + page.
        PW_CMD_COL_LO,  // Low column nibble 0.
        PW_CMD_COL_HI,  // High column nibble 0.
        PW_FETCH,       // Frame memory read strobe.
        PW_WAIT_MEM,    // Read data returns.
        PW_SEND_DATA,   // Pixel byte held at arbiter.
        PW_NEXT_PAGE
    } pw_state_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_SELECT,      // cs_n low, first bit set up.
        TX_SHIFT,       // Eight sclk periods.
        TX_RELEASE      // Done pulse, cs_n high.
    } tx_state_t;

endpackage

// ==== oled_init_rom.sv ====
`timescale 1ns/1ps

module oled_init_rom (
    input  logic                clk,
    input  logic                rst_n,
    input  oled_pkg::oled_byte_t index,
    output oled_pkg::oled_byte_t data,
    output oled_pkg::oled_dc_t   dc
);

    oled_pkg::oled_byte_t rom_word;
    logic                 in_range;

    assign in_range = (index <= oled_pkg::oled_byte_t'(oled_pkg::INIT_LEN));

    // SSD1306 power-on list.
    always_comb begin
        case (index)
            8'd0:    rom_word = 8'hAE;  // Display off.
            8'd1:    rom_word = 8'h00;  // Low column address.
            8'd2:    rom_word = 8'h10;  // High column address.
            8'd3:    rom_word = 8'h40;  // Start line 0.
            8'd4:    rom_word = 8'h81;  // Contrast control.
            8'd5:    rom_word = 8'hCF;  // Contrast value.
            8'd6:    rom_word = 8'hA1;  // Segment remap.
            8'd7:    rom_word = 8'hC8;  // COM scan reversed.
            8'd8:    rom_word = 8'hA6;  // Normal display.
            8'd9:    rom_word = 8'hA8;  // Multiplex ratio.
            8'd10:   rom_word = 8'h3F;  // 1/64 duty.
            8'd11:   rom_word = 8'hD3;  // Display offset.
            8'd12:   rom_word = 8'h00;  // No offset.
            8'd13:   rom_word = 8'hD5;  // Clock divide / oscillator.
            8'd14:   rom_word = 8'h80;
            8'd15:   rom_word = 8'hD9;  // Pre-charge period.
            8'd16:   rom_word = 8'hF1;  // 15 clocks precharge, 1 discharge.
            8'd17:   rom_word = 8'hDA;  // COM pin config.
            8'd18:   rom_word = 8'h12;
            8'd19:   rom_word = 8'hDB;  // VCOMH level.
            8'd20:   rom_word = 8'h40;
            8'd21:   rom_word = 8'h20;  // Addressing mode.
            8'd22:   rom_word = 8'h02;  // Page mode.
            8'd23:   rom_word = 8'h8D;  // Charge pump.
            8'd24:   rom_word = 8'h14;  // Pump on.
            8'd25:   rom_word = 8'hA4;  // Follow RAM content.
            8'd26:   rom_word = 8'hA6;  // Not inverted.
            8'd27:   rom_word = 8'hAF;  // Display on.
            // End marker, never sent.
            default: rom_word = 8'hAF;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // One cycle of read latency.
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data <= '0;
            dc   <= oled_pkg::DC_CMD;
        end else if (in_range) begin
            data <= rom_word;
            dc   <= oled_pkg::DC_CMD;  // Whole list is commands.
        end
        // Out of range holds the last word.
    end

endmodule

// ==== oled_init_seq.sv ====
`timescale 1ns/1ps

module oled_init_seq (
    input  logic                 clk,
    input  logic                 rst_n,
    output oled_pkg::oled_byte_t rom_index,
    input  oled_pkg::oled_byte_t rom_byte,
    input  oled_pkg::oled_dc_t   rom_dc,
    output logic                 req,
    output oled_pkg::oled_byte_t byte_out,
    output oled_pkg::oled_dc_t   dc_out,
    input  logic                 done_pulse,
    output logic                 init_done
);

    oled_pkg::init_state_t state;

    // Index of the last real command.
    localparam oled_pkg::oled_byte_t LAST_IDX = oled_pkg::oled_byte_t'(oled_pkg::INIT_LEN - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= oled_pkg::INIT_FETCH;
            rom_index <= '0;
            req       <= 1'b0;
            byte_out  <= '0;
            dc_out    <= oled_pkg::DC_CMD;
            init_done <= 1'b0;
        end else begin
            case (state)
                oled_pkg::INIT_FETCH: begin
                    state <= oled_pkg::INIT_WAIT_ROM;  // ROM samples index now.
                end
                oled_pkg::INIT_WAIT_ROM: begin
                    byte_out <= rom_byte;
                    dc_out   <= rom_dc;
                    req      <= 1'b1;
                    state    <= oled_pkg::INIT_REQUEST;
                end
                oled_pkg::INIT_REQUEST: begin
                    if (done_pulse) begin
                        req <= 1'b0;
                        if (rom_index == LAST_IDX) begin
                            init_done <= 1'b1;  // Marker entry is skipped.
                            state     <= oled_pkg::INIT_FINISHED;
                        end else begin
                            rom_index <= rom_index + 8'd1;
                            state     <= oled_pkg::INIT_FETCH;
                        end
                    end
                end
                default: begin
                    state <= oled_pkg::INIT_FINISHED;  // Stays here until reset.
                end
            endcase
        end
    end

endmodule

// ==== oled_page_writer.sv ====
`timescale 1ns/1ps

module oled_page_writer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     init_done,
    input  logic                     frame_start,
    output logic                     frame_busy,
    output oled_pkg::oled_pix_addr_t pix_addr,
    output logic                     pix_rd,
    input  oled_pkg::oled_byte_t     pix_data,
    output logic                     req,
    output oled_pkg::oled_byte_t     byte_out,
    output oled_pkg::oled_dc_t       dc_out,
    input  logic                     done_pulse
);

    localparam oled_pkg::oled_byte_t CMD_PAGE_BASE = 8'hB0;
    localparam oled_pkg::oled_byte_t CMD_COL_LO    = 8'h00;
    localparam oled_pkg::oled_byte_t CMD_COL_HI    = 8'h10;
    localparam oled_pkg::oled_page_t LAST_PAGE = oled_pkg::oled_page_t'(oled_pkg::NUM_PAGES - 1);
    localparam oled_pkg::oled_col_t  LAST_COL  = oled_pkg::oled_col_t'(oled_pkg::NUM_COLS - 1);

    oled_pkg::pw_state_t  state;
    oled_pkg::oled_page_t page;
    oled_pkg::oled_col_t  col;

    // Memory sees the read strobe in FETCH, data valid in WAIT_MEM.
    assign pix_rd   = (state == oled_pkg::PW_FETCH);
    assign pix_addr = {page, col};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= oled_pkg::PW_IDLE;
            page       <= '0;
            col        <= '0;
            frame_busy <= 1'b0;
            req        <= 1'b0;
            byte_out   <= '0;
            dc_out     <= oled_pkg::DC_CMD;
        end else begin
            case (state)
                oled_pkg::PW_IDLE: begin
                    // Early or overlapping starts fall through.
                    if (frame_start && init_done && !frame_busy) begin
                        frame_busy <= 1'b1;
                        page       <= '0;
                        byte_out   <= CMD_PAGE_BASE;
                        dc_out     <= oled_pkg::DC_CMD;
                        req        <= 1'b1;
                        state      <= oled_pkg::PW_CMD_PAGE;
                    end
                end
                oled_pkg::PW_CMD_PAGE: if (done_pulse) begin
                    byte_out <= CMD_COL_LO;  // Request stays up, new byte.
                    state    <= oled_pkg::PW_CMD_COL_LO;
                end
                oled_pkg::PW_CMD_COL_LO: if (done_pulse) begin
                    byte_out <= CMD_COL_HI;
                    state    <= oled_pkg::PW_CMD_COL_HI;
                end
                oled_pkg::PW_CMD_COL_HI: if (done_pulse) begin
                    req   <= 1'b0;
                    col   <= '0;
                    state <= oled_pkg::PW_FETCH;
                end
                oled_pkg::PW_FETCH: begin
                    state <= oled_pkg::PW_WAIT_MEM;
                end
                oled_pkg::PW_WAIT_MEM: begin
                    byte_out <= pix_data;
                    dc_out   <= oled_pkg::DC_DATA;
                    req      <= 1'b1;
                    state    <= oled_pkg::PW_SEND_DATA;
                end
                oled_pkg::PW_SEND_DATA: if (done_pulse) begin
                    req <= 1'b0;  // Next read waits for this accept.
                    if (col != LAST_COL) begin
                        col   <= col + 7'd1;
                        state <= oled_pkg::PW_FETCH;
                    end else if (page == LAST_PAGE) begin
                        frame_busy <= 1'b0;  // Frame complete.
                        state      <= oled_pkg::PW_IDLE;
                    end else begin
                        state <= oled_pkg::PW_NEXT_PAGE;
                    end
                end
                default: begin  // Next page.
                    page     <= page + 3'd1;
                    byte_out <= CMD_PAGE_BASE | oled_pkg::oled_byte_t'(page + 3'd1);
                    dc_out   <= oled_pkg::DC_CMD;
                    req      <= 1'b1;
                    state    <= oled_pkg::PW_CMD_PAGE;
                end
            endcase
        end
    end

endmodule

// ==== oled_spi_arbiter.sv ====
`timescale 1ns/1ps

module oled_spi_arbiter (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 init_req,
    input  oled_pkg::oled_byte_t init_byte,
    input  oled_pkg::oled_dc_t   init_dc,
    output logic                 init_done_pulse,
    input  logic                 pw_req,
    input  oled_pkg::oled_byte_t pw_byte,
    input  oled_pkg::oled_dc_t   pw_dc,
    output logic                 pw_done_pulse,
    output logic                 tx_start,
    output oled_pkg::oled_byte_t tx_byte,
    output oled_pkg::oled_dc_t   tx_dc,
    input  logic                 tx_done
);

    logic busy;      // Byte in flight.
    logic owner_pw;  // Low when init owns the link.
    logic grant;

    // Init sequencer always wins.
    assign grant = !busy && (init_req || pw_req);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            owner_pw <= 1'b0;
            tx_start <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            if (grant) begin
                busy     <= 1'b1;  // Held through tx_done.
                owner_pw <= !init_req;
                tx_start <= 1'b1;
            end else if (tx_done) begin
                busy <= 1'b0;
            end
        end
    end

    // Winner's byte, captured with the grant.
    always_ff @(posedge clk) begin
        if (grant) begin
            tx_byte <= init_req ? init_byte : pw_byte;
            tx_dc   <= init_req ? init_dc : pw_dc;
        end
    end

    // Done goes back to the owner only.
    assign init_done_pulse = tx_done && !owner_pw;
    assign pw_done_pulse   = tx_done && owner_pw;

endmodule

// ==== oled_spi_tx.sv ====
`timescale 1ns/1ps

module oled_spi_tx #(
    parameter int CLK_DIV = 4  // sclk half-period in clk cycles.
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  oled_pkg::oled_byte_t byte_in,
    input  oled_pkg::oled_dc_t   dc_in,
    output logic                 done,
    output logic                 sclk,
    output logic                 mosi,
    output oled_pkg::oled_dc_t   dc,
    output logic                 cs_n
);

    localparam int DIV_W = $clog2(CLK_DIV + 1);

    oled_pkg::tx_state_t  state;
    logic [DIV_W-1:0]     div_cnt;
    logic [2:0]           bit_cnt;
    oled_pkg::oled_byte_t shift_reg;

    ////////////////////////////////////////////////////////////////////////////
    // Mode 0, MSB first. start to done is 16*CLK_DIV+2 cycles.
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= oled_pkg::TX_IDLE;
            div_cnt   <= '0;
            bit_cnt   <= '0;
            shift_reg <= '0;
            done      <= 1'b0;
            sclk      <= 1'b0;
            mosi      <= 1'b0;
            dc        <= oled_pkg::DC_CMD;
            cs_n      <= 1'b1;
        end else begin
            case (state)
                oled_pkg::TX_IDLE: if (start) begin
                    shift_reg <= byte_in;
                    dc        <= dc_in;  // Stable while selected.
                    cs_n      <= 1'b0;
                    state     <= oled_pkg::TX_SELECT;
                end
                oled_pkg::TX_SELECT: begin
                    mosi    <= shift_reg[7];  // First bit, sclk low.
                    div_cnt <= '0;
                    bit_cnt <= '0;
                    state   <= oled_pkg::TX_SHIFT;
                end
                oled_pkg::TX_SHIFT: begin
                    if (div_cnt == DIV_W'(CLK_DIV - 1)) begin
                        div_cnt <= '0;
                        if (!sclk) begin
                            sclk <= 1'b1;  // Panel samples here.
                        end else begin
                            sclk <= 1'b0;
                            if (bit_cnt == 3'd7) begin
                                cs_n  <= 1'b1;
                                done  <= 1'b1;
                                state <= oled_pkg::TX_RELEASE;
                            end else begin
                                bit_cnt   <= bit_cnt + 3'd1;
                                mosi      <= shift_reg[6];
                                shift_reg <= {shift_reg[6:0], 1'b0};
                            end
                        end
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                default: begin  // Release.
                    done  <= 1'b0;
                    mosi  <= 1'b0;
                    state <= oled_pkg::TX_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== oled_top.sv ====
`timescale 1ns/1ps

module oled_top #(
    parameter int CLK_DIV = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     frame_start,
    output logic                     frame_busy,
    output logic                     init_done,
    output oled_pkg::oled_pix_addr_t pix_addr,
    output logic                     pix_rd,
    input  oled_pkg::oled_byte_t     pix_data,
    output logic                     sclk,
    output logic                     mosi,
    output oled_pkg::oled_dc_t       dc,
    output logic                     cs_n
);

    // ROM side.
    oled_pkg::oled_byte_t rom_index;
    oled_pkg::oled_byte_t rom_byte;
    oled_pkg::oled_dc_t   rom_dc;

    // Requesters into the arbiter.
    logic                 init_req;
    oled_pkg::oled_byte_t init_byte;
    oled_pkg::oled_dc_t   init_dc;
    logic                 init_done_pulse;
    logic                 pw_req;
    oled_pkg::oled_byte_t pw_byte;
    oled_pkg::oled_dc_t   pw_dc;
    logic                 pw_done_pulse;

    // Arbiter to transmitter.
    logic                 tx_start;
    oled_pkg::oled_byte_t tx_byte;
    oled_pkg::oled_dc_t   tx_dc;
    logic                 tx_done;

    oled_init_rom u_rom (
        .clk   (clk),
        .rst_n (rst_n),
        .index (rom_index),
        .data  (rom_byte),
        .dc    (rom_dc)
    );

    oled_init_seq u_init_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .rom_index  (rom_index),
        .rom_byte   (rom_byte),
        .rom_dc     (rom_dc),
        .req        (init_req),
        .byte_out   (init_byte),
        .dc_out     (init_dc),
        .done_pulse (init_done_pulse),
        .init_done  (init_done)
    );

    oled_page_writer u_page_writer (
        .clk         (clk),
        .rst_n       (rst_n),
        .init_done   (init_done),
        .frame_start (frame_start),
        .frame_busy  (frame_busy),
        .pix_addr    (pix_addr),
        .pix_rd      (pix_rd),
        .pix_data    (pix_data),
        .req         (pw_req),
        .byte_out    (pw_byte),
        .dc_out      (pw_dc),
        .done_pulse  (pw_done_pulse)
    );

    oled_spi_arbiter u_arbiter (
        .clk             (clk),
        .rst_n           (rst_n),
        .init_req        (init_req),
        .init_byte       (init_byte),
        .init_dc         (init_dc),
        .init_done_pulse (init_done_pulse),
        .pw_req          (pw_req),
        .pw_byte         (pw_byte),
        .pw_dc           (pw_dc),
        .pw_done_pulse   (pw_done_pulse),
        .tx_start        (tx_start),
        .tx_byte         (tx_byte),
        .tx_dc           (tx_dc),
        .tx_done         (tx_done)
    );

    oled_spi_tx #(
        .CLK_DIV (CLK_DIV)
    ) u_spi_tx (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (tx_start),
        .byte_in (tx_byte),
        .dc_in   (tx_dc),
        .done    (tx_done),
        .sclk    (sclk),
        .mosi    (mosi),
        .dc      (dc),
        .cs_n    (cs_n)
    );

endmodule

// ==== tb_oled.sv ====
`timescale 1ns/1ps

module tb_oled;

    localparam int CLK_DIV     = 4;
    localparam int NUM_PAGES   = oled_pkg::NUM_PAGES;
    localparam int NUM_COLS    = oled_pkg::NUM_COLS;
    localparam int INIT_LEN    = oled_pkg::INIT_LEN;
    localparam int FRAME_BYTES = NUM_PAGES * (3 + NUM_COLS);  // 1048 bytes.
    localparam int BYTE_GAP    = 16 * CLK_DIV + 2 + 8;        // One byte plus slack.
    localparam int INIT_LIMIT  = INIT_LEN * BYTE_GAP * 2;
    localparam int FRAME_LIMIT = FRAME_BYTES * BYTE_GAP * 2;
    localparam logic [31:0] SEED = 32'he566;

    logic                     clk;
    logic                     rst_n;
    logic                     frame_start;
    logic                     frame_busy;
    logic                     init_done;
    oled_pkg::oled_pix_addr_t pix_addr;
    logic                     pix_rd;
    oled_pkg::oled_byte_t     pix_data;
    logic                     sclk;
    logic                     mosi;
    oled_pkg::oled_dc_t       dc;
    logic                     cs_n;

    logic [31:0] golden [0:32];        // Init bytes, page bases, seeds.
    logic [7:0]  frame_mem [0:1023];   // Pixel memory owned by the user.
    logic [8:0]  byte_q [$];           // {dc, byte} as seen on the pins.

    int err_count    = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int errs_at_test = 0;
    int spi_faults   = 0;

    // SPI monitor state.
    logic       prev_cs_n;
    logic       prev_sclk;
    logic       sel_dc;
    logic       dc_moved;
    logic [7:0] shift_byte;
    int         rise_count;

    oled_top #(
        .CLK_DIV (CLK_DIV)
    ) u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame_start (frame_start),
        .frame_busy  (frame_busy),
        .init_done   (init_done),
        .pix_addr    (pix_addr),
        .pix_rd      (pix_rd),
        .pix_data    (pix_data),
        .sclk        (sclk),
        .mosi        (mosi),
        .dc          (dc),
        .cs_n        (cs_n)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 100 MHz.
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers.
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            err_count++;
        end
    endtask

    // Address goes into every step, so each location differs.
    task automatic fill_memory(input logic [31:0] seed);
        logic [31:0] s;
        s = SEED ^ seed;
        for (int a = 0; a < 1024; a++) begin
            s = xorshift32(s ^ 32'(a));
            frame_mem[a] = s[7:0] ^ s[23:16];
        end
    endtask

    function automatic logic [8:0] byte_at(input int idx);
        if (idx < byte_q.size()) return byte_q[idx];
        return 9'bx;  // Missing byte.
    endfunction

    task automatic start_test();
        errs_at_test = err_count;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (err_count == errs_at_test) begin
            $display("test %-22s ok", name);
        end else begin
            tests_failed++;
            $display("test %-22s failed with %0d errors", name, err_count - errs_at_test);
        end
    endtask

    task automatic pulse_frame_start();
        @(posedge clk);
        #1 frame_start = 1'b1;
        @(posedge clk);
        #1 frame_start = 1'b0;
    endtask

    task automatic check_reset_pins(input string name);
        check_value({name, " cs_n"}, 1, cs_n);
        check_value({name, " sclk"}, 0, sclk);
        check_value({name, " init_done"}, 0, init_done);
        check_value({name, " frame_busy"}, 0, frame_busy);
    endtask

    task automatic wait_init_done(output int busy_cycles);
        int cycles;
        busy_cycles = 0;
        cycles      = 0;
        while (init_done !== 1'b1 && cycles < INIT_LIMIT) begin
            @(posedge clk);
            #1;
            cycles++;
            if (frame_busy === 1'b1) busy_cycles++;  // Early start leaking through.
        end
        if (init_done !== 1'b1) begin
            $display("Timeout: init_done did not rise within %0d cycles.", INIT_LIMIT);
            err_count++;
        end
    endtask

    task automatic wait_busy(input logic level, input int limit, input string what);
        int cycles;
        cycles = 0;
        while (frame_busy !== level && cycles < limit) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (frame_busy !== level) begin
            $display("Timeout: %s did not happen within %0d cycles.", what, limit);
            err_count++;
        end
    endtask

    task automatic wait_bytes(input int count, input int limit);
        int cycles;
        cycles = 0;
        while (byte_q.size() < count && cycles < limit) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (byte_q.size() < count) begin
            $display("Timeout: only %0d of %0d SPI bytes arrived.", byte_q.size(), count);
            err_count++;
        end
    endtask

    // Three address commands per page, then the page's pixels.
    task automatic check_frame(input int first, input string name);
        int         idx;
        logic [8:0] expected;
        idx = first;
        for (int p = 0; p < NUM_PAGES; p++) begin
            check_value($sformatf("%s page %0d B0", name, p),
                        {oled_pkg::DC_CMD, golden[28][7:0] + 8'(p)}, byte_at(idx));
            check_value($sformatf("%s page %0d col lo", name, p),
                        {oled_pkg::DC_CMD, golden[29][7:0]}, byte_at(idx + 1));
            check_value($sformatf("%s page %0d col hi", name, p),
                        {oled_pkg::DC_CMD, golden[30][7:0]}, byte_at(idx + 2));
            idx = idx + 3;
            for (int c = 0; c < NUM_COLS; c++) begin
                expected = {oled_pkg::DC_DATA, frame_mem[p * NUM_COLS + c]};
                check_value($sformatf("%s page %0d col %0d", name, p, c),
                            expected, byte_at(idx));
                idx++;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Frame memory and SPI pin decoder.
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (pix_rd === 1'b1) pix_data <= #1 frame_mem[pix_addr];  // Next-cycle data.
    end

    // Edges of cs_n and sclk found against the previous clk sample.
    always @(posedge clk) begin
        if (rst_n !== 1'b1) begin
            prev_cs_n = 1'b1;
            prev_sclk = 1'b0;
        end else begin
            if (prev_cs_n && !cs_n) begin  // Select.
                shift_byte = '0;
                rise_count = 0;
                sel_dc     = dc;
                dc_moved   = 1'b0;
            end
            if (!cs_n) begin
                if (sclk && !prev_sclk) begin
                    shift_byte = {shift_byte[6:0], mosi};  // MSB first.
                    rise_count++;
                end
                if (dc !== sel_dc) dc_moved = 1'b1;
            end else if (sclk && !prev_sclk) begin
                $display("SPI error: sclk rose while cs_n was high.");
                spi_faults++;
                err_count++;
            end
            if (!prev_cs_n && cs_n) begin  // Deselect ends the byte.
                if (rise_count != 8 || dc_moved) spi_faults++;
                check_value("spi_framing sclk edges", 8, rise_count);
                check_value("spi_framing dc stable", 0, dc_moved);
                byte_q.push_back({sel_dc, shift_byte});
            end
            prev_cs_n = cs_n;
            prev_sclk = sclk;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence.
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int base;
        int busy_early;
        rst_n       = 1'b0;
        frame_start = 1'b0;
        pix_data    <= '0;
        $readmemh("oled_golden.txt", golden);
        if ($isunknown(golden[32])) begin
            $display("Golden file oled_golden.txt could not be read completely.");
            err_count++;
        end
        fill_memory(golden[31]);

        start_test();
        repeat (16) begin
            @(posedge clk);
            #1;
            check_reset_pins("reset_state");
        end
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        check_reset_pins("reset_state after");
        end_test("reset_state");

        // Start requested while the init list is still going out.
        start_test();
        repeat (10) @(posedge clk);
        #1;
        check_value("early_start init_done", 0, init_done);
        pulse_frame_start();
        wait_init_done(busy_early);
        check_value("early_start busy cycles", 0, busy_early);
        end_test("early_start_ignored");

        start_test();
        wait_bytes(INIT_LEN, BYTE_GAP);
        check_value("init_sequence count", INIT_LEN, byte_q.size());
        for (int i = 0; i < INIT_LEN; i++) begin
            check_value($sformatf("init_sequence byte %0d", i),
                        {oled_pkg::DC_CMD, golden[i][7:0]}, byte_at(i));
        end
        repeat (BYTE_GAP * 4) @(posedge clk);
        #1;
        check_value("init_sequence quiet count", INIT_LEN, byte_q.size());
        check_value("init_sequence quiet busy", 0, frame_busy);
        end_test("init_sequence");

        start_test();
        base = byte_q.size();
        pulse_frame_start();
        wait_busy(1'b1, 8, "frame_busy rise");
        wait_busy(1'b0, FRAME_LIMIT, "end of first frame");
        wait_bytes(base + FRAME_BYTES, BYTE_GAP);
        check_value("full_frame count", FRAME_BYTES, byte_q.size() - base);
        check_frame(base, "full_frame");
        end_test("full_frame");

        // Second seed, plus a start pulse in the middle of the frame.
        start_test();
        base = byte_q.size();
        fill_memory(golden[32]);
        pulse_frame_start();
        wait_busy(1'b1, 8, "frame_busy rise for second frame");
        repeat (BYTE_GAP * 10) @(posedge clk);
        #1;
        check_value("second_frame busy at pulse", 1, frame_busy);
        pulse_frame_start();
        wait_busy(1'b0, FRAME_LIMIT, "end of second frame");
        wait_bytes(base + FRAME_BYTES, BYTE_GAP);
        check_frame(base, "second_frame");
        repeat (BYTE_GAP * 4) @(posedge clk);
        #1;
        check_value("second_frame count", FRAME_BYTES, byte_q.size() - base);
        check_value("second_frame quiet busy", 0, frame_busy);
        end_test("busy_start_second_frame");

        start_test();
        check_value("spi_framing faults", 0, spi_faults);
        check_value("spi_framing total", INIT_LEN + 2 * FRAME_BYTES, byte_q.size());
        end_test("spi_framing");

        $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, err_count);
        if (err_count == 0 && tests_failed == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== oled_golden.txt ====
// Words 0-27: init command bytes in send order, all sent with D/C low.
// Words 28-30: page command bases (page, column low, column high).
// Words 31-32: frame memory seeds, XORed with the base seed.
AE 00 10 40
81 CF A1 C8
A6 A8 3F D3
00 D5 80 D9
F1 DA 12 DB
40 20 02 8D
14 A4 A6 AF
// Page addressing.
B0 00 10
// First frame keeps the base seed.
00000000
// Second frame.
3C9D71A5

// ==== tb.f ====
oled_pkg.sv
oled_init_rom.sv
oled_init_seq.sv
oled_page_writer.sv
oled_spi_arbiter.sv
oled_spi_tx.sv
oled_top.sv
tb_oled.sv

// ==== Bender.yml ====
package:
  name: oled_ssd1306_spi

sources:
  - files:
      - oled_pkg.sv
      - oled_init_rom.sv
      - oled_init_seq.sv
      - oled_page_writer.sv
      - oled_spi_arbiter.sv
      - oled_spi_tx.sv
      - oled_top.sv
  - target: test
    files:
      - tb_oled.sv
